//--- Makefile
SIM_TOOL  = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
RUN_FLAGS = +verilator+error+limit+1000
TOP       = tb_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "Something failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- blob_tracker_top.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

module blob_tracker_top #(
	parameter int image_w = 640,
	parameter int image_h = 480
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic [23:0]        sink_data_i,
	input  logic               sink_valid_i,
	input  logic               sink_sop_i,
	input  logic               sink_eop_i,
	output logic               sink_ready_o,
	output logic [23:0]        source_data_o,
	output logic               source_valid_o,
	output logic               source_sop_o,
	output logic               source_eop_o,
	input  logic               source_ready_i,
	input  logic               s_chipselect_i,
	input  logic               s_read_i,
	input  logic [`ADDR_W-1:0] s_address_i,
	output logic [`DATA_W-1:0] s_readdata_o,
	input  logic               mode_i
);
	logic [`NUM_COLOURS-1:0] confirmed;
	vision_pkg::box_t        boxes [`NUM_COLOURS];

	pixel_if pix ();

	pixel_front #(.image_w(image_w), .image_h(image_h)) u_front (
		.clk(clk), .reset_n(reset_n),
		.sink_data_i(sink_data_i), .sink_valid_i(sink_valid_i),
		.sink_sop_i(sink_sop_i), .sink_eop_i(sink_eop_i),
		.source_valid_i(source_valid_o), .source_ready_i(source_ready_i),
		.sink_ready_o(sink_ready_o), .pix(pix)
	);

	////////////////////
	// one tracker per colour

	for (genvar k = 0; k < `NUM_COLOURS; k++) begin : g_track
		colour_tracker #(.colour_idx(k)) u_track (
			.clk(clk), .reset_n(reset_n), .pix(pix),
			.confirmed_o(confirmed[k]), .box_o(boxes[k])
		);
	end

	frame_overlay u_overlay (
		.clk(clk), .reset_n(reset_n), .mode_i(mode_i), .source_ready_i(source_ready_i),
		.confirmed_i(confirmed), .boxes_i(boxes), .pix(pix),
		.source_data_o(source_data_o), .source_valid_o(source_valid_o),
		.source_sop_o(source_sop_o), .source_eop_o(source_eop_o)
	);

	csr_regs u_csr (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect_i(s_chipselect_i), .s_read_i(s_read_i), .s_address_i(s_address_i),
		.frame_end_i(pix.frame_end), .boxes_i(boxes), .s_readdata_o(s_readdata_o)
	);
endmodule

//--- colour_tracker.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

module colour_tracker #(
	parameter int colour_idx = 0
) (
	input  logic             clk,
	input  logic             reset_n,
	pixel_if.tracker         pix,
	output logic             confirmed_o,
	output vision_pkg::box_t box_o
);
	localparam vision_pkg::colour_win_t win = vision_pkg::colour_win[colour_idx];

	logic                    step;
	logic                    match;
	// matches of the previous beats, newest in bit 0
	logic [`CONFIRM_RUN-2:0] run_q;
	vision_pkg::box_t        work_q;

	assign step = pix.adv & pix.beat_valid;
	assign match = pix.is_video & ~pix.sop &
		(pix.hsv.hue >= win.hue_lo) & (pix.hsv.hue <= win.hue_hi) &
		(pix.hsv.sat > win.sat_min) & (pix.hsv.val > win.val_min);
	assign confirmed_o = match & (&run_q);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run_q <= '0;
			work_q.valid <= 1'b0;
			box_o.valid <= 1'b0;
		end else begin
			if (step) begin
				if (pix.sop) begin
					run_q <= '0;
					work_q.valid <= 1'b0;
				end else begin
					run_q <= {run_q[`CONFIRM_RUN-3:0], match};
					if (confirmed_o)
						work_q.valid <= 1'b1;
				end
			end
			if (pix.frame_end)
				box_o.valid <= work_q.valid;
		end
	end

	////////////////////
	// box grows around confirmed pixels

	always_ff @(posedge clk) begin
		if (step && confirmed_o) begin
			// first hit of the frame seeds all four edges
			if (!work_q.valid || pix.x < work_q.left)
				work_q.left <= pix.x;
			if (!work_q.valid || pix.x > work_q.right)
				work_q.right <= pix.x;
			if (!work_q.valid || pix.y < work_q.top)
				work_q.top <= pix.y;
			if (!work_q.valid || pix.y > work_q.bottom)
				work_q.bottom <= pix.y;
		end
		if (pix.frame_end) begin
			box_o.left <= work_q.left;
			box_o.right <= work_q.right;
			box_o.top <= work_q.top;
			box_o.bottom <= work_q.bottom;
		end
	end
endmodule

//--- compile.f
+incdir+.
vision_pkg.sv
pixel_if.sv
pixel_front.sv
colour_tracker.sv
frame_overlay.sv
csr_regs.sv
blob_tracker_top.sv
tb_sva.sv
tb_top.sv

//--- csr_regs.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

module csr_regs (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              s_chipselect_i,
	input  logic              s_read_i,
	input  logic [`ADDR_W-1:0] s_address_i,
	input  logic              frame_end_i,
	input  vision_pkg::box_t  boxes_i [`NUM_COLOURS],
	output logic [`DATA_W-1:0] s_readdata_o
);
	logic [`DATA_W-1:0] frame_cnt;
	logic [`ADDR_W-1:0] box_off;
	logic [`ADDR_W-2:0] box_idx;
	vision_pkg::box_t   sel_box;
	logic [`DATA_W-1:0] box_word;

	// even offset is the horizontal word, odd the vertical
	assign box_off = s_address_i - `REG_BOX_BASE;
	assign box_idx = box_off[`ADDR_W-1:1];

	always_comb begin
		sel_box = '0;
		if (box_idx < `NUM_COLOURS)
			sel_box = boxes_i[box_idx];
		if (box_off[0])
			box_word = {sel_box.valid, 4'b0, sel_box.top, 5'b0, sel_box.bottom};
		else
			box_word = {sel_box.valid, 4'b0, sel_box.left, 5'b0, sel_box.right};
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			s_readdata_o <= '0;
		end else begin
			if (frame_end_i)
				frame_cnt <= frame_cnt + 1'b1;
			if (s_chipselect_i && s_read_i) begin
				case (s_address_i)
					`REG_ID:     s_readdata_o <= `ID_WORD;
					`REG_FRAMES: s_readdata_o <= frame_cnt;
					default:     s_readdata_o <= box_word;
				endcase
			end
		end
	end
endmodule

//--- frame_overlay.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

module frame_overlay (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    mode_i,
	input  logic                    source_ready_i,
	input  logic [`NUM_COLOURS-1:0] confirmed_i,
	input  vision_pkg::box_t        boxes_i [`NUM_COLOURS],
	pixel_if.overlay                pix,
	output logic [23:0]             source_data_o,
	output logic                    source_valid_o,
	output logic                    source_sop_o,
	output logic                    source_eop_o
);
	logic             load;
	logic             line_hit;
	logic             high_hit;
	vision_pkg::rgb_t line_rgb;
	vision_pkg::rgb_t high_rgb;
	logic [7:0]       grey;
	logic [23:0]      out_word;

	assign load = ~source_valid_o | source_ready_i;

	// lowest colour index wins, so scan downwards
	always_comb begin
		line_hit = 1'b0;
		high_hit = 1'b0;
		line_rgb = '0;
		high_rgb = '0;
		for (int k = `NUM_COLOURS - 1; k >= 0; k--) begin
			if (boxes_i[k].valid && (pix.x == boxes_i[k].left || pix.x == boxes_i[k].right ||
					pix.y == boxes_i[k].top || pix.y == boxes_i[k].bottom)) begin
				line_hit = 1'b1;
				line_rgb = vision_pkg::box_rgb[k];
			end
			if (confirmed_i[k]) begin
				high_hit = 1'b1;
				high_rgb = vision_pkg::hi_rgb[k];
			end
		end
	end

	// g/2 + r/4 + b/4
	assign grey = {1'b0, pix.word.pix.g[7:1]} + {2'b0, pix.word.pix.r[7:2]} +
		{2'b0, pix.word.pix.b[7:2]};

	assign out_word = !(mode_i && pix.is_video && !pix.sop) ? pix.word :
		line_hit ? line_rgb : high_hit ? high_rgb : {grey, grey, grey};

	always_ff @(posedge clk) begin
		if (!reset_n)
			source_valid_o <= 1'b0;
		else if (load)
			source_valid_o <= pix.beat_valid;
	end

	always_ff @(posedge clk) begin
		if (load && pix.beat_valid) begin
			source_data_o <= out_word;
			source_sop_o <= pix.sop;
			source_eop_o <= pix.eop;
		end
	end
endmodule

//--- pixel_front.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

module pixel_front #(
	parameter int image_w = 640,
	parameter int image_h = 480
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic [23:0] sink_data_i,
	input  logic        sink_valid_i,
	input  logic        sink_sop_i,
	input  logic        sink_eop_i,
	input  logic        source_valid_i,
	input  logic        source_ready_i,
	output logic        sink_ready_o,
	pixel_if.front      pix
);
	localparam int x_last = image_w - 1;
	localparam int y_last = image_h - 1;

	vision_pkg::stream_word_u sink_word;
	logic                     accept;
	logic [7:0]               c_max;
	logic [7:0]               c_min;
	logic [7:0]               c_delta;
	logic [17:0]              hue_num;
	logic [17:0]              hue_deg;
	logic [15:0]              sat_q;

	// whole pipe moves when stage 2 is empty or draining
	assign pix.adv = ~source_valid_i | source_ready_i;
	assign sink_ready_o = pix.adv;
	assign accept = pix.adv & sink_valid_i;
	assign sink_word = sink_data_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pix.beat_valid <= 1'b0;
			pix.is_video <= 1'b0;
			pix.x <= '0;
			pix.y <= '0;
			pix.frame_end <= 1'b0;
		end else begin
			pix.frame_end <= pix.adv & pix.beat_valid & pix.eop & pix.is_video;
			if (pix.adv)
				pix.beat_valid <= sink_valid_i;
			if (accept) begin
				if (sink_sop_i) begin
					pix.is_video <= (sink_word.hdr.packet_type == 4'd0);
					pix.x <= '0;
					pix.y <= '0;
				end else if (pix.is_video && !pix.sop) begin
					// first pixel after the header keeps 0,0
					if (pix.x == x_last[`COORD_W-1:0]) begin
						pix.x <= '0;
						pix.y <= (pix.y == y_last[`COORD_W-1:0]) ? '0 : pix.y + 1'b1;
					end else begin
						pix.x <= pix.x + 1'b1;
					end
				end
			end
		end
	end

	// payload only follows accepted beats, so sop is that of the last one
	always_ff @(posedge clk) begin
		if (accept) begin
			pix.word <= sink_data_i;
			pix.sop <= sink_sop_i;
			pix.eop <= sink_eop_i;
		end
	end

	////////////////////
	// rgb to hsv

	always_comb begin
		c_max = (pix.word.pix.r > pix.word.pix.g) ?
			((pix.word.pix.r > pix.word.pix.b) ? pix.word.pix.r : pix.word.pix.b) :
			((pix.word.pix.g > pix.word.pix.b) ? pix.word.pix.g : pix.word.pix.b);
		c_min = (pix.word.pix.r < pix.word.pix.g) ?
			((pix.word.pix.r < pix.word.pix.b) ? pix.word.pix.r : pix.word.pix.b) :
			((pix.word.pix.g < pix.word.pix.b) ? pix.word.pix.g : pix.word.pix.b);
		c_delta = c_max - c_min;
		// red wins ties, then green
		if (c_max == pix.word.pix.r) begin
			if (pix.word.pix.g >= pix.word.pix.b)
				hue_num = 18'd60 * (pix.word.pix.g - pix.word.pix.b);
			else
				hue_num = 18'd360 * c_delta - 18'd60 * (pix.word.pix.b - pix.word.pix.g);
		end else if (c_max == pix.word.pix.g) begin
			hue_num = 18'd120 * c_delta + 18'd60 * pix.word.pix.b - 18'd60 * pix.word.pix.r;
		end else begin
			hue_num = 18'd240 * c_delta + 18'd60 * pix.word.pix.r - 18'd60 * pix.word.pix.g;
		end
		hue_deg = (c_delta == 8'd0) ? 18'd0 : hue_num / c_delta;
		sat_q = (c_max == 8'd0) ? 16'd0 : (16'd255 * c_delta) / c_max;
	end

	assign pix.hsv.hue = hue_deg[9:1];
	assign pix.hsv.sat = sat_q[7:0];
	assign pix.hsv.val = c_max;
endmodule

//--- pixel_if.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

// one stage-1 beat with its position and colour
interface pixel_if;
	logic                      adv;
	logic                      beat_valid;
	vision_pkg::stream_word_u  word;
	logic                      sop;
	logic                      eop;
	logic                      is_video;
	logic [`COORD_W-1:0]       x;
	logic [`COORD_W-1:0]       y;
	vision_pkg::hsv_t          hsv;
	// end of a video frame, one cycle
	logic                      frame_end;

	modport front (
		output adv, beat_valid, word, sop, eop, is_video, x, y, hsv, frame_end
	);

	modport tracker (
		input adv, beat_valid, sop, is_video, x, y, hsv, frame_end
	);

	// stage 2 works out its own load from the source handshake
	modport overlay (
		input beat_valid, word, sop, eop, is_video, x, y
	);
endinterface

//--- tb_sva.sv
`timescale 1ns/1ps

module tb_sva (
	input logic        clk,
	input logic        reset_n,
	input logic        mode_i,
	input logic [23:0] sink_data_i,
	input logic        sink_valid_i,
	input logic        sink_sop_i,
	input logic        sink_eop_i,
	input logic        sink_ready_o,
	input logic [23:0] source_data_o,
	input logic        source_valid_o,
	input logic        source_sop_o,
	input logic        source_eop_o,
	input logic        source_ready_i
);
	int          fail_cnt = 0;
	logic        seen_accept;
	logic        push;
	logic        pop;
	logic [25:0] in_beat;
	// accepted beats not yet sent, oldest in hist0
	logic [25:0] hist0;
	logic [25:0] hist1;
	logic [1:0]  hist_cnt;

	assign push = sink_valid_i & sink_ready_o;
	assign pop = source_valid_o & source_ready_i;
	assign in_beat = {sink_sop_i, sink_eop_i, sink_data_i};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			seen_accept <= 1'b0;
			hist_cnt <= 2'd0;
		end else begin
			if (push)
				seen_accept <= 1'b1;
			case ({push, pop})
				2'b10: begin
					if (hist_cnt == 2'd0)
						hist0 <= in_beat;
					else
						hist1 <= in_beat;
					hist_cnt <= hist_cnt + 2'd1;
				end
				2'b01: begin
					hist0 <= hist1;
					hist_cnt <= hist_cnt - 2'd1;
				end
				2'b11: begin
					if (hist_cnt == 2'd1) begin
						hist0 <= in_beat;
					end else begin
						hist0 <= hist1;
						hist1 <= in_beat;
					end
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////
	// stream checks

	a_idle_after_reset: assert property (@(posedge clk) disable iff (!reset_n)
		!seen_accept |-> !source_valid_o)
		else begin
			$error("output valid before any beat was accepted");
			fail_cnt++;
		end

	// sop and eop pass through in every mode
	a_beat_order: assert property (@(posedge clk) disable iff (!reset_n)
		pop |-> (hist_cnt != 2'd0) && ({source_sop_o, source_eop_o} == hist0[25:24]))
		else begin
			$error("output beat framing differs from the accepted beat");
			fail_cnt++;
		end

	a_plain_data: assert property (@(posedge clk) disable iff (!reset_n)
		(pop && !mode_i) |-> (source_data_o == hist0[23:0]))
		else begin
			$error("output data differs from the accepted beat");
			fail_cnt++;
		end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
		(source_valid_o && !source_ready_i) |=>
			(source_valid_o && $stable({source_data_o, source_sop_o, source_eop_o})))
		else begin
			$error("output beat changed while stalled");
			fail_cnt++;
		end
endmodule

//--- tb_top.sv
`timescale 1ns/1ps
`include "vision_defines.svh"

module tb_top;
	localparam int img_w = 16;
	localparam int img_h = 8;
	localparam int n_pix = img_w * img_h;
	localparam int other_beats = 6;
	// two frames, two short packets, register reads, reset
	localparam int stim_cycles = 2 * (n_pix + 1) + 2 * other_beats + 2 * 12 + 10;
	localparam int timeout_cycles = 8 * stim_cycles;
	// boxes expected after the first frame
	localparam int red_l = 6;
	localparam int red_r = 9;
	localparam int red_t = 2;
	localparam int red_b = 5;
	localparam int grn_l = 13;
	localparam int grn_r = 13;
	localparam int grn_t = 6;
	localparam int grn_b = 7;

	logic               clk;
	logic               reset_n = 1'b0;
	logic [23:0]        sink_data_i = '0;
	logic               sink_valid_i = 1'b0;
	logic               sink_sop_i = 1'b0;
	logic               sink_eop_i = 1'b0;
	logic               source_ready_i = 1'b1;
	logic               s_chipselect_i = 1'b0;
	logic               s_read_i = 1'b0;
	logic [`ADDR_W-1:0] s_address_i = '0;
	logic               mode_i = 1'b0;
	logic               sink_ready_o;
	logic [23:0]        source_data_o;
	logic               source_valid_o;
	logic               source_sop_o;
	logic               source_eop_o;
	logic [`DATA_W-1:0] s_readdata_o;

	logic [23:0] img [n_pix];
	logic [25:0] out_q [$];
	logic [25:0] other_q [$];
	int          cycle_cnt = 0;
	int          errors = 0;
	int          errs_at_start = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	string       cur_test;

	blob_tracker_top #(.image_w(img_w), .image_h(img_h)) DUT (.*);

	bind blob_tracker_top tb_sva u_sva (
		.clk(clk), .reset_n(reset_n), .mode_i(mode_i),
		.sink_data_i(sink_data_i), .sink_valid_i(sink_valid_i),
		.sink_sop_i(sink_sop_i), .sink_eop_i(sink_eop_i), .sink_ready_o(sink_ready_o),
		.source_data_o(source_data_o), .source_valid_o(source_valid_o),
		.source_sop_o(source_sop_o), .source_eop_o(source_eop_o),
		.source_ready_i(source_ready_i)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// random stalls on the output side
	always @(negedge clk) begin
		if (!reset_n)
			source_ready_i <= 1'b1;
		else
			source_ready_i <= ($urandom % 4) != 0;
	end

	always @(posedge clk) begin
		if (reset_n && source_valid_o && source_ready_i)
			out_q.push_back({source_sop_o, source_eop_o, source_data_o});
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles) begin
			$display("Timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////
	// helpers

	function automatic int block_colour(int x, int y);
		if (x >= 4 && x <= 9 && y >= 2 && y <= 5)
			return 1;
		if (x >= 11 && x <= 13 && y >= 6 && y <= 7)
			return 2;
		return 0;
	endfunction

	function automatic logic [31:0] box_word(logic valid, int a, int b);
		return {valid, 4'b0, 11'(a), 5'b0, 11'(b)};
	endfunction

	// line colour first, then highlight, then grey
	function automatic logic [23:0] expected_overlay(int x, int y, logic [23:0] rgb, int conf);
		logic [7:0] grey;
		if (x == red_l || x == red_r || y == red_t || y == red_b)
			return 24'hff0000;
		if (x == grn_l || x == grn_r || y == grn_t || y == grn_b)
			return 24'h1cfc03;
		if (conf == 1)
			return 24'hff0000;
		if (conf == 2)
			return 24'h04bd42;
		grey = (rgb[15:8] >> 1) + (rgb[23:16] >> 2) + (rgb[7:0] >> 2);
		return {grey, grey, grey};
	endfunction

	task automatic build_image();
		logic [7:0] v;
		for (int i = 0; i < n_pix; i++) begin
			v = 8'($urandom);
			case (block_colour(i % img_w, i / img_w))
				1: img[i] = 24'hff0000;
				2: img[i] = 24'h00ff00;
				default: img[i] = {v, v, v};
			endcase
		end
	endtask

	task automatic send_beat(input logic [23:0] data, input logic sop, input logic eop);
		@(negedge clk);
		sink_data_i = data;
		sink_sop_i = sop;
		sink_eop_i = eop;
		sink_valid_i = 1'b1;
		@(posedge clk);
		while (!sink_ready_o)
			@(posedge clk);
	endtask

	task automatic stop_input();
		@(negedge clk);
		sink_valid_i = 1'b0;
		sink_sop_i = 1'b0;
		sink_eop_i = 1'b0;
	endtask

	task automatic send_frame();
		send_beat(24'h000000, 1'b1, 1'b0);
		for (int i = 0; i < n_pix; i++)
			send_beat(img[i], 1'b0, i == n_pix - 1);
		stop_input();
	endtask

	// packet type 5 with random payload
	task automatic send_other_packet();
		logic [25:0] beat;
		other_q.delete();
		for (int i = 0; i < other_beats; i++) begin
			beat[25] = (i == 0);
			beat[24] = (i == other_beats - 1);
			beat[23:0] = (i == 0) ? 24'h000005 : 24'($urandom);
			other_q.push_back(beat);
			send_beat(beat[23:0], beat[25], beat[24]);
		end
		stop_input();
	endtask

	task automatic wait_outputs(input int n);
		while (out_q.size() < n)
			@(negedge clk);
	endtask

	task automatic read_reg(input logic [`ADDR_W-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		s_chipselect_i = 1'b1;
		s_read_i = 1'b1;
		s_address_i = addr;
		@(negedge clk);
		s_chipselect_i = 1'b0;
		s_read_i = 1'b0;
		data = s_readdata_o;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
	endtask

	task automatic finish_test();
		int now_errs;
		now_errs = errors + DUT.u_sva.fail_cnt;
		if (now_errs == errs_at_start) begin
			tests_passed++;
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", cur_test, now_errs - errs_at_start);
		end
		errs_at_start = now_errs;
	endtask

	////////////////////
	// test sequence

	initial begin
		logic [31:0] rd;
		int          base;
		int          run_red;
		int          run_grn;
		int          conf;
		void'($urandom(34672));
		repeat (10) @(negedge clk);
		reset_n = 1'b1;

		start_test("reset_idle");
		repeat (3) @(negedge clk);
		assert (!source_valid_o)
		else begin
			$display("source valid went high with no input after reset");
			errors++;
		end
		finish_test();

		start_test("frame_passthrough");
		build_image();
		send_frame();
		wait_outputs(n_pix + 1);
		// no extra beat may follow the frame
		repeat (4) @(negedge clk);
		check_value("packet count", 32'(n_pix + 1), 32'(out_q.size()));
		check_value("last eop", 32'd1, 32'(out_q[n_pix][24]));
		finish_test();

		start_test("box_readback");
		read_reg(`REG_BOX_BASE, rd);
		check_value("red horizontal", box_word(1'b1, red_l, red_r), rd);
		read_reg(`REG_BOX_BASE + 3'd1, rd);
		check_value("red vertical", box_word(1'b1, red_t, red_b), rd);
		read_reg(`REG_BOX_BASE + 3'd2, rd);
		check_value("green horizontal", box_word(1'b1, grn_l, grn_r), rd);
		read_reg(`REG_BOX_BASE + 3'd3, rd);
		check_value("green vertical", box_word(1'b1, grn_t, grn_b), rd);
		read_reg(`REG_BOX_BASE + 3'd4, rd);
		check_value("orange valid", 32'd0, 32'(rd[31]));
		finish_test();

		start_test("id_and_frames");
		read_reg(`REG_ID, rd);
		check_value("id word", `ID_WORD, rd);
		read_reg(`REG_FRAMES, rd);
		check_value("frames after video", 32'd1, rd);
		send_other_packet();
		wait_outputs(n_pix + 1 + other_beats);
		read_reg(`REG_FRAMES, rd);
		check_value("frames after type 5", 32'd1, rd);
		finish_test();

		start_test("overlay_frame");
		mode_i = 1'b1;
		base = out_q.size();
		build_image();
		send_frame();
		wait_outputs(base + n_pix + 1);
		check_value("header", 32'd0, 32'(out_q[base][23:0]));
		run_red = 0;
		run_grn = 0;
		for (int i = 0; i < n_pix; i++) begin
			run_red = (block_colour(i % img_w, i / img_w) == 1) ? run_red + 1 : 0;
			run_grn = (block_colour(i % img_w, i / img_w) == 2) ? run_grn + 1 : 0;
			conf = (run_red >= `CONFIRM_RUN) ? 1 : (run_grn >= `CONFIRM_RUN) ? 2 : 0;
			check_value($sformatf("pixel x%0d y%0d", i % img_w, i / img_w),
				32'(expected_overlay(i % img_w, i / img_w, img[i], conf)),
				32'(out_q[base + 1 + i][23:0]));
		end
		read_reg(`REG_FRAMES, rd);
		check_value("frames after overlay", 32'd2, rd);
		finish_test();

		start_test("non_video_overlay");
		base = out_q.size();
		send_other_packet();
		wait_outputs(base + other_beats);
		for (int i = 0; i < other_beats; i++)
			check_value($sformatf("beat %0d", i), 32'(other_q[i]), 32'(out_q[base + i]));
		mode_i = 1'b0;
		finish_test();

		repeat (4) @(negedge clk);
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors + DUT.u_sva.fail_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end
endmodule

//--- vision_defines.svh
`ifndef VISION_DEFINES_SVH
`define VISION_DEFINES_SVH

////////////////////
// widths

`define COORD_W       11
`define DATA_W        32
`define ADDR_W        3

////////////////////
// register map
// colour k has its horizontal word at REG_BOX_BASE + 2k, vertical word right after

`define REG_ID        3'd0
`define REG_FRAMES    3'd1
`define REG_BOX_BASE  3'd2
`define ID_WORD       32'h1234EEE2

// tracked colours in index order: red, green, orange
`define NUM_COLOURS   3
// matching pixels in a row before a colour counts as confirmed
`define CONFIRM_RUN   3

`endif

//--- vision_pkg.sv
`include "vision_defines.svh"

package vision_pkg;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// header view of the first beat of a packet
	typedef struct packed {
		logic [19:0] rsvd;
		logic [3:0]  packet_type;
	} pkt_hdr_t;

	// packet type 0 is video
	typedef union packed {
		rgb_t     pix;
		pkt_hdr_t hdr;
	} stream_word_u;

	// hue is degrees halved, 0 to 179
	typedef struct packed {
		logic [8:0] hue;
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	typedef struct packed {
		logic                valid;
		logic [`COORD_W-1:0] left;
		logic [`COORD_W-1:0] right;
		logic [`COORD_W-1:0] top;
		logic [`COORD_W-1:0] bottom;
	} box_t;

	// sat and val must lie strictly above their minimum
	typedef struct packed {
		logic [8:0] hue_lo;
		logic [8:0] hue_hi;
		logic [7:0] sat_min;
		logic [7:0] val_min;
	} colour_win_t;

	localparam colour_win_t colour_win [`NUM_COLOURS] = '{
		'{hue_lo: 9'd0,  hue_hi: 9'd11, sat_min: 8'd130, val_min: 8'd50},
		// green accepts val of 50 and up
		'{hue_lo: 9'd50, hue_hi: 9'd75, sat_min: 8'd105, val_min: 8'd49},
		'{hue_lo: 9'd13, hue_hi: 9'd25, sat_min: 8'd133, val_min: 8'd108}
	};

	localparam rgb_t box_rgb [`NUM_COLOURS] = '{24'hff0000, 24'h1cfc03, 24'hf0f0f0};
	localparam rgb_t hi_rgb [`NUM_COLOURS] = '{24'hff0000, 24'h04bd42, 24'hff7700};

endpackage
